// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing -Mdir obj_dir
TOP       ?= esaxi_tb
RTL_TOP   ?= esaxi
FILELIST  ?= esaxi.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: axi_read/esaxi_read.sv
`timescale 1ns/1ps
`default_nettype none

module esaxi_read
   import esaxi_pkg::*;
#(
   parameter int          axi_addr_width = 30,
   parameter logic [11:0] read_tag_addr  = 12'h810
)
(
   input  wire                      s_axi_aclk,
   input  wire                      s_axi_aresetn,
   // read address channel
   input  wire [axi_addr_width-1:0] s_axi_araddr,
   input  wire [1:0]                s_axi_arburst,
   input  wire [7:0]                s_axi_arlen,
   input  wire [2:0]                s_axi_arsize,
   input  wire                      s_axi_arvalid,
   output logic                     s_axi_arready,
   // read data channel
   input  wire                      s_axi_rready,
   output logic                     s_axi_rvalid,
   output logic [31:0]              s_axi_rdata,
   output logic [1:0]               s_axi_rresp,
   output logic                     s_axi_rlast,
   // emesh read request
   output logic                     emrq_access,
   output logic [1:0]               emrq_datamode,
   output logic [3:0]               emrq_ctrlmode,
   output emesh_addr_u              emrq_dstaddr,
   output logic [31:0]              emrq_srcaddr,
   // emesh read response
   input  wire                      emrr_access,
   input  wire [31:0]               emrr_data,
   output logic                     emrr_rd_en,
   // local register readback
   input  wire                      local_rd_valid,
   input  wire [31:0]               local_rd_data,
   // link config
   input  wire [3:0]                ecfg_tx_ctrlmode,
   input  wire [11:0]               ecfg_coreid
);

   logic        read_active;   // ar accepted, last beat not yet taken
   logic        ractive_q;     // delayed copy for the leading edge
   logic        rsp_pending;   // request out, no answer yet
   logic [31:0] rd_addr;
   logic [7:0]  rd_len;        // beats left after the current one
   logic [1:0]  rd_size;
   logic [1:0]  rd_burst;
   logic        r_beat;
   logic        last_rd_beat;
   logic        rsp_take;
   logic [31:0] rsp_data;

   assign r_beat       = s_axi_rvalid & s_axi_rready;
   assign last_rd_beat = r_beat & s_axi_rlast;
   assign s_axi_rresp  = resp_okay;
   assign emrq_srcaddr = {read_tag_addr, {(32-12){1'b0}}};   // tag routes the answer back
   assign emrr_rd_en   = emrr_access & ~local_rd_valid;      // pop remote answers at once
   assign rsp_take     = rsp_pending & (emrr_access | local_rd_valid);
   assign rsp_data     = local_rd_valid ? local_rd_data : emrr_data;   // local wins

   // ####################
   // address channel
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b0;
         read_active   <= 1'b0;
      end
      else
      begin
         if (!s_axi_arready && !read_active)
            s_axi_arready <= 1'b1;
         else if (s_axi_arvalid)
            s_axi_arready <= 1'b0;
         if (s_axi_arready && s_axi_arvalid)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;          // one burst at a time
      end
   end

   // beat counter and rlast
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rd_len      <= 8'd0;
         s_axi_rlast <= 1'b0;
      end
      else if (s_axi_arready && s_axi_arvalid)
      begin
         rd_len      <= s_axi_arlen;
         s_axi_rlast <= (s_axi_arlen == 8'd0);   // single beat burst
      end
      else if (r_beat)
      begin
         rd_len      <= rd_len - 1'b1;
         s_axi_rlast <= (rd_len == 8'd1);
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_arready && s_axi_arvalid)
      begin
         rd_addr  <= {ecfg_coreid[11 -: 32-axi_addr_width], s_axi_araddr};
         rd_size  <= s_axi_arsize[1:0];
         rd_burst <= s_axi_arburst;
      end
      else if (r_beat && rd_burst == burst_incr)
         rd_addr <= {rd_addr[31:addr_lsb] + 1'b1, {addr_lsb{1'b0}}};
   end

   // ####################
   // request generation
   // ####################
   assign emrq_dstaddr.word = rd_addr;   // follows the running address

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q   <= 1'b0;
         emrq_access <= 1'b0;
      end
      else
      begin
         ractive_q   <= read_active;
         emrq_access <= (read_active & ~ractive_q) | (r_beat & ~s_axi_rlast);   // one per beat
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      emrq_datamode <= rd_size;
      emrq_ctrlmode <= ecfg_tx_ctrlmode;
   end

   // ####################
   // response formatting
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rsp_pending  <= 1'b0;
         s_axi_rvalid <= 1'b0;
      end
      else
      begin
         if (emrq_access)
            rsp_pending <= 1'b1;
         else if (rsp_take)
            rsp_pending <= 1'b0;      // first answer closes the beat
         if (rsp_take)
            s_axi_rvalid <= 1'b1;
         else if (s_axi_rready)
            s_axi_rvalid <= 1'b0;
      end
   end

   // narrow data copied across the whole word
   always_ff @(posedge s_axi_aclk)
   begin
      if (rsp_take)
      begin
         case (rd_size)
            size_byte: s_axi_rdata <= {4{rsp_data[7:0]}};
            size_half: s_axi_rdata <= {2{rsp_data[15:0]}};
            default:   s_axi_rdata <= rsp_data;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: axi_write/esaxi_write.sv
`timescale 1ns/1ps
`default_nettype none

module esaxi_write
   import esaxi_pkg::*;
#(
   parameter int axi_addr_width = 30
)
(
   input  wire                      s_axi_aclk,
   input  wire                      s_axi_aresetn,
   // write address channel
   input  wire [axi_addr_width-1:0] s_axi_awaddr,
   input  wire [1:0]                s_axi_awburst,
   input  wire [2:0]                s_axi_awsize,
   input  wire                      s_axi_awvalid,
   output logic                     s_axi_awready,
   // write data channel
   input  wire [31:0]               s_axi_wdata,
   input  wire [3:0]                s_axi_wstrb,
   input  wire                      s_axi_wlast,
   input  wire                      s_axi_wvalid,
   output logic                     s_axi_wready,
   // write response channel
   input  wire                      s_axi_bready,
   output logic                     s_axi_bvalid,
   output logic [1:0]               s_axi_bresp,
   // emesh write packet
   input  wire                      emwr_progfull,
   output logic                     emwr_access,
   output logic [1:0]               emwr_datamode,
   output logic [3:0]               emwr_ctrlmode,
   output emesh_addr_u              emwr_dstaddr,
   output logic [31:0]              emwr_data,
   // link config
   input  wire [3:0]                ecfg_tx_ctrlmode,
   input  wire [11:0]               ecfg_coreid
);

   logic                write_active;   // between aw and last w beat
   logic [31:0]         wr_addr;        // address of the current beat
   logic [1:0]          wr_size;
   logic [1:0]          wr_burst;
   logic                wr_beat;
   logic                last_wr_beat;
   logic [1:0]          strb_shift;     // count of low zero strobes
   logic                al_valid;       // aligning stage holds a beat
   logic [31:addr_lsb]  al_word;
   logic [1:0]          al_lsb;
   logic [31:0]         al_data;

   assign wr_beat      = s_axi_wready & s_axi_wvalid;
   assign last_wr_beat = wr_beat & s_axi_wlast;
   assign s_axi_bresp  = resp_okay;   // never errors

   // ####################
   // address channel
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b0;
         write_active  <= 1'b0;
      end
      else
      begin
         if (!s_axi_awready && !write_active && !s_axi_bvalid)
            s_axi_awready <= 1'b1;        // idle, open for a new burst
         else if (s_axi_awvalid)
            s_axi_awready <= 1'b0;
         if (s_axi_awready && s_axi_awvalid)
            write_active <= 1'b1;
         else if (last_wr_beat)
            write_active <= 1'b0;
      end
   end

   // burst attributes and running address
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_awready && s_axi_awvalid)
      begin
         wr_addr  <= {ecfg_coreid[11 -: 32-axi_addr_width], s_axi_awaddr};
         wr_size  <= s_axi_awsize[1:0];
         wr_burst <= s_axi_awburst;
      end
      else if (wr_beat && wr_burst == burst_incr)
         wr_addr <= {wr_addr[31:addr_lsb] + 1'b1, {addr_lsb{1'b0}}};   // next word
   end

   // ####################
   // data and response
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_wready <= 1'b0;
      else if (last_wr_beat)
         s_axi_wready <= 1'b0;
      else if (write_active)
         s_axi_wready <= ~emwr_progfull;   // stall while tx fifo nearly full
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_bvalid <= 1'b0;
      else if (last_wr_beat)
         s_axi_bvalid <= 1'b1;
      else if (s_axi_bready)
         s_axi_bvalid <= 1'b0;             // held until host takes it
   end

   // first enabled byte lane decides the shift
   always_comb
   begin
      casez (s_axi_wstrb)
         4'b???1: strb_shift = 2'd0;
         4'b??10: strb_shift = 2'd1;
         4'b?100: strb_shift = 2'd2;
         default: strb_shift = 2'd3;
      endcase
   end

   // ####################
   // emesh packet
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         al_valid    <= 1'b0;
         emwr_access <= 1'b0;
      end
      else
      begin
         al_valid    <= wr_beat;
         emwr_access <= al_valid;          // two cycles after the w beat
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (wr_beat)
      begin
         al_word <= wr_addr[31:addr_lsb];   // address before the increment
         al_lsb  <= strb_shift;
         al_data <= s_axi_wdata >> {strb_shift, 3'b000};
      end
      if (al_valid)
      begin
         emwr_dstaddr.word <= {al_word, al_lsb};
         emwr_data         <= al_data;
         emwr_datamode     <= wr_size;
         emwr_ctrlmode     <= ecfg_tx_ctrlmode;
      end
   end

endmodule

`default_nettype wire

// File: bench/esaxi_tb_cases.svh
`ifndef esaxi_tb_cases_svh
`define esaxi_tb_cases_svh

// columns: op, rnd, axi addr, len, size, burst, strobe, data,
//          expected emesh addr, expected data or rdata, expected select {mmr,rx,tx,embox}

localparam logic [1:0] op_write = 2'd0;
localparam logic [1:0] op_read  = 2'd1;
localparam logic [1:0] op_stall = 2'd2;   // write held off by progfull

typedef struct packed {
   logic [1:0]  op;
   logic        rnd;        // data word from $urandom
   logic [29:0] addr;
   logic [7:0]  len;
   logic [2:0]  size;
   logic [1:0]  burst;
   logic [3:0]  strb;
   logic [31:0] data;
   logic [31:0] exp_addr;   // first beat
   logic [31:0] exp_data;   // first beat
   logic [3:0]  sel;
} case_t;

localparam int n_cases = 14;

case_t cases [n_cases];

task automatic load_cases;
   // single full strobe write, then the three shifted strobes
   cases[0]  = '{op_write, 1'b0, 30'h0000_1000, 8'd0, 3'd2, 2'b01, 4'hf,
                 32'h1122_3344, 32'h8000_1000, 32'h1122_3344, 4'b0000};
   cases[1]  = '{op_write, 1'b0, 30'h0000_1010, 8'd0, 3'd2, 2'b01, 4'b0010,
                 32'h1122_3344, 32'h8000_1011, 32'h0011_2233, 4'b0000};
   cases[2]  = '{op_write, 1'b0, 30'h0000_1020, 8'd0, 3'd2, 2'b01, 4'b0100,
                 32'h1122_3344, 32'h8000_1022, 32'h0000_1122, 4'b0000};
   cases[3]  = '{op_write, 1'b0, 30'h0000_1030, 8'd0, 3'd2, 2'b01, 4'b1000,
                 32'h1122_3344, 32'h8000_1033, 32'h0000_0011, 4'b0000};
   // bursts, incrementing then fixed
   cases[4]  = '{op_write, 1'b1, 30'h0000_2000, 8'd3, 3'd2, 2'b01, 4'hf,
                 32'h0, 32'h8000_2000, 32'h0, 4'b0000};
   cases[5]  = '{op_write, 1'b0, 30'h0000_3000, 8'd2, 3'd2, 2'b00, 4'hf,
                 32'h0a00_0000, 32'h8000_3000, 32'h0a00_0000, 4'b0000};
   // remote reads, word burst then narrow sizes
   cases[6]  = '{op_read, 1'b1, 30'h0000_4000, 8'd1, 3'd2, 2'b01, 4'h0,
                 32'h0, 32'h8000_4000, 32'h0, 4'b0000};
   cases[7]  = '{op_read, 1'b0, 30'h0000_4100, 8'd0, 3'd0, 2'b01, 4'h0,
                 32'ha1b2_c3d4, 32'h8000_4100, 32'hd4d4_d4d4, 4'b0000};
   cases[8]  = '{op_read, 1'b0, 30'h0000_4200, 8'd0, 3'd1, 2'b01, 4'h0,
                 32'ha1b2_c3d4, 32'h8000_4200, 32'hc3d4_c3d4, 4'b0000};
   // local register block
   cases[9]  = '{op_write, 1'b0, 30'h010f_0040, 8'd0, 3'd2, 2'b01, 4'hf,
                 32'hcafe_0001, 32'h810f_0040, 32'hcafe_0001, 4'b1000};
   cases[10] = '{op_write, 1'b0, 30'h010c_0008, 8'd0, 3'd2, 2'b01, 4'hf,
                 32'hcafe_0002, 32'h810c_0008, 32'hcafe_0002, 4'b0001};
   cases[11] = '{op_read, 1'b0, 30'h010e_0010, 8'd0, 3'd2, 2'b01, 4'h0,
                 32'h0, 32'h810e_0010, 32'h2222_000e, 4'b0100};
   cases[12] = '{op_read, 1'b0, 30'h010d_0020, 8'd0, 3'd2, 2'b01, 4'h0,
                 32'h0, 32'h810d_0020, 32'h3333_000d, 4'b0010};
   // back-pressure on a short burst
   cases[13] = '{op_stall, 1'b0, 30'h0000_5000, 8'd1, 3'd2, 2'b01, 4'hf,
                 32'h5566_0000, 32'h8000_5000, 32'h5566_0000, 4'b0000};
endtask

`endif

// File: bench/esaxi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module esaxi_tb;

   logic        s_axi_aclk;
   logic        s_axi_aresetn;
   logic [29:0] s_axi_awaddr;
   logic [1:0]  s_axi_awburst;
   logic [2:0]  s_axi_awsize;
   logic        s_axi_awvalid;
   wire         s_axi_awready;
   logic [31:0] s_axi_wdata;
   logic [3:0]  s_axi_wstrb;
   logic        s_axi_wlast;
   logic        s_axi_wvalid;
   wire         s_axi_wready;
   logic        s_axi_bready;
   wire         s_axi_bvalid;
   wire [1:0]   s_axi_bresp;
   logic [29:0] s_axi_araddr;
   logic [1:0]  s_axi_arburst;
   logic [7:0]  s_axi_arlen;
   logic [2:0]  s_axi_arsize;
   logic        s_axi_arvalid;
   wire         s_axi_arready;
   logic        s_axi_rready;
   wire         s_axi_rvalid;
   wire [31:0]  s_axi_rdata;
   wire [1:0]   s_axi_rresp;
   wire         s_axi_rlast;
   logic        emwr_progfull;
   wire         emwr_access;
   wire [1:0]   emwr_datamode;
   wire [3:0]   emwr_ctrlmode;
   wire [31:0]  emwr_dstaddr;
   wire [31:0]  emwr_data;
   wire         emrq_access;
   wire [1:0]   emrq_datamode;
   wire [3:0]   emrq_ctrlmode;
   wire [31:0]  emrq_dstaddr;
   wire [31:0]  emrq_srcaddr;
   logic        emrr_access;
   logic [31:0] emrr_data;
   wire         emrr_rd_en;
   wire         mi_we;
   wire [19:0]  mi_addr;
   wire [31:0]  mi_din;
   wire         mi_ecfg_sel;
   wire         mi_rx_emmu_sel;
   wire         mi_tx_emmu_sel;
   wire         mi_embox_sel;
   logic [31:0] mi_ecfg_dout;
   logic [31:0] mi_rx_emmu_dout;
   logic [31:0] mi_tx_emmu_dout;
   logic [31:0] mi_embox_dout;
   logic [3:0]  ecfg_tx_ctrlmode;
   logic [11:0] ecfg_coreid;

   `include "esaxi_tb_cases.svh"

   localparam int          cycle_limit = n_cases * 64 + 16;   // rows plus reset
   localparam logic [31:0] src_tag     = 32'h8100_0000;       // read tag, low bits zero

   int errors       = 0;
   int checks       = 0;
   int cycles       = 0;
   int emrq_count   = 0;
   int bvalid_count = 0;

   // packets still owed by the write path
   logic [31:0] exp_wr_addr [$];
   logic [31:0] exp_wr_data [$];
   logic [3:0]  exp_wr_sel [$];
   logic [1:0]  exp_wr_mode [$];
   int          exp_wr_cycle [$];   // cycle of the w beat

   esaxi uut (.*);

   // #####################
   // clock and timeout
   // #####################
   initial
   begin
      s_axi_aclk = 1'b0;
      forever #5 s_axi_aclk = ~s_axi_aclk;
   end

   always @(posedge s_axi_aclk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   always @(posedge emrq_access) emrq_count = emrq_count + 1;   // pulses never touch
   always @(posedge s_axi_bvalid) bvalid_count = bvalid_count + 1;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp)
      begin
         errors = errors + 1;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // #####################
   // emesh write monitor
   // #####################
   always @(negedge s_axi_aclk)
   begin
      if (s_axi_aresetn && emwr_access)
      begin
         if (exp_wr_addr.size() == 0)
         begin
            errors = errors + 1;
            $display("emesh write packet at cycle %0d that no beat asked for", cycles);
         end
         else
         begin
            compare("emwr_access delay", cycles - exp_wr_cycle.pop_front(), 32'd2);
            compare("emwr_dstaddr", emwr_dstaddr, exp_wr_addr[0]);
            compare("emwr_data", emwr_data, exp_wr_data[0]);
            compare("emwr_datamode", emwr_datamode, exp_wr_mode.pop_front());
            compare("emwr_ctrlmode", emwr_ctrlmode, ecfg_tx_ctrlmode);
            compare("mi_sel", {mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel, mi_embox_sel},
                    exp_wr_sel[0]);
            compare("mi_we", mi_we, exp_wr_sel[0] != 4'b0000);
            if (exp_wr_sel[0] != 4'b0000)
            begin
               compare("mi_addr", mi_addr, exp_wr_addr[0][19:0]);   // group and offset
               compare("mi_din", mi_din, exp_wr_data[0]);
            end
            void'(exp_wr_addr.pop_front());
            void'(exp_wr_data.pop_front());
            void'(exp_wr_sel.pop_front());
         end
      end
   end

   // #####################
   // write and read drivers
   // #####################
   task automatic run_write(input case_t c, input logic [31:0] d0, input logic [31:0] e0);
      int i;
      int b0;
      b0            = bvalid_count;
      s_axi_awaddr  = c.addr;
      s_axi_awburst = c.burst;
      s_axi_awsize  = c.size;
      s_axi_awvalid = 1'b1;
      while (!s_axi_awready) @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      s_axi_awvalid = 1'b0;
      for (i = 0; i <= c.len; i++)
      begin
         s_axi_wdata  = d0 + i;
         s_axi_wstrb  = c.strb;
         s_axi_wlast  = (i == c.len);
         s_axi_wvalid = 1'b1;
         if (c.op == op_stall && i == 0)
         begin
            repeat (8)
            begin
               @(negedge s_axi_aclk);
               compare("s_axi_wready", s_axi_wready, 32'd0);   // held off by progfull
            end
            emwr_progfull = 1'b0;
         end
         while (!s_axi_wready) @(negedge s_axi_aclk);
         exp_wr_addr.push_back(c.burst == 2'b01 ? c.exp_addr + 4 * i : c.exp_addr);
         exp_wr_data.push_back(e0 + i);
         exp_wr_sel.push_back(c.sel);
         exp_wr_mode.push_back(c.size[1:0]);
         exp_wr_cycle.push_back(cycles);
         @(negedge s_axi_aclk);
      end
      s_axi_wvalid = 1'b0;
      s_axi_wlast  = 1'b0;
      while (!s_axi_bvalid) @(negedge s_axi_aclk);
      compare("s_axi_bresp", s_axi_bresp, 32'd0);
      while (exp_wr_addr.size() != 0) @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      compare("bvalid count", bvalid_count - b0, 32'd1);   // one response per burst
   endtask

   task automatic run_read(input case_t c, input logic [31:0] d0, input logic [31:0] e0);
      int i;
      int delay;
      int q0;
      s_axi_araddr  = c.addr;
      s_axi_arburst = c.burst;
      s_axi_arlen   = c.len;
      s_axi_arsize  = c.size;
      s_axi_arvalid = 1'b1;
      while (!s_axi_arready) @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      s_axi_arvalid = 1'b0;
      for (i = 0; i <= c.len; i++)
      begin
         while (!emrq_access) @(negedge s_axi_aclk);
         q0 = emrq_count;   // this beat's request already counted
         compare("emrq_dstaddr", emrq_dstaddr,
                 c.burst == 2'b01 ? c.exp_addr + 4 * i : c.exp_addr);
         compare("emrq_srcaddr", emrq_srcaddr, src_tag);
         compare("emrq_datamode", emrq_datamode, c.size[1:0]);
         compare("emrq_ctrlmode", emrq_ctrlmode, ecfg_tx_ctrlmode);
         compare("mi_sel", {mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel, mi_embox_sel}, c.sel);
         if (c.sel != 4'b0000)
         begin
            compare("mi_addr", mi_addr, c.exp_addr[19:0]);
            compare("mi_we", mi_we, 32'd0);
         end
         else
         begin
            // remote responder answers after a random wait
            delay = $urandom_range(5, 1);
            repeat (delay) @(negedge s_axi_aclk);
            emrr_access = 1'b1;
            emrr_data   = d0 + i;
            @(negedge s_axi_aclk);
            compare("emrr_rd_en", emrr_rd_en, 32'd1);   // remote answer popped
            emrr_access = 1'b0;
         end
         while (!s_axi_rvalid) @(negedge s_axi_aclk);
         repeat (3) @(negedge s_axi_aclk);   // hold rready low for a while
         compare("emrq pulses before r handshake", emrq_count - q0, 32'd0);
         compare("s_axi_rdata", s_axi_rdata, e0 + i);
         compare("s_axi_rlast", s_axi_rlast, i == c.len);
         compare("s_axi_rresp", s_axi_rresp, 32'd0);
         s_axi_rready = 1'b1;
         @(negedge s_axi_aclk);
         s_axi_rready = 1'b0;
         compare("emrq_access after r handshake", emrq_access, i != c.len);   // next beat
      end
   endtask

   // #####################
   // main sequence
   // #####################
   initial
   begin : stimulus
      int          r;
      logic [31:0] d;
      logic [31:0] e;
      case_t       c;
      void'($urandom(70));
      s_axi_aresetn    = 1'b0;
      s_axi_awaddr     = '0;
      s_axi_awburst    = 2'b01;
      s_axi_awsize     = 3'd2;
      s_axi_awvalid    = 1'b0;
      s_axi_wdata      = '0;
      s_axi_wstrb      = 4'h0;
      s_axi_wlast      = 1'b0;
      s_axi_wvalid     = 1'b0;
      s_axi_bready     = 1'b1;   // response taken at once
      s_axi_araddr     = '0;
      s_axi_arburst    = 2'b01;
      s_axi_arlen      = 8'd0;
      s_axi_arsize     = 3'd2;
      s_axi_arvalid    = 1'b0;
      s_axi_rready     = 1'b0;
      emwr_progfull    = 1'b0;
      emrr_access      = 1'b0;
      emrr_data        = '0;
      mi_ecfg_dout     = 32'h1111_000f;   // register model words
      mi_rx_emmu_dout  = 32'h2222_000e;
      mi_tx_emmu_dout  = 32'h3333_000d;
      mi_embox_dout    = 32'h4444_000c;
      ecfg_tx_ctrlmode = 4'h5;
      ecfg_coreid      = 12'h810;
      load_cases();
      repeat (16) @(negedge s_axi_aclk);
      compare("reset state", {s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready,
              s_axi_rvalid, s_axi_rlast, emwr_access, emrq_access, emrr_rd_en}, 32'd0);
      s_axi_aresetn = 1'b1;
      for (r = 0; r < n_cases; r++)
      begin
         c = cases[r];
         d = c.data;
         e = c.exp_data;
         if (c.rnd)
         begin
            d = $urandom;
            e = d;   // full word rows only
         end
         if (c.op == op_read)
            run_read(c, d, e);
         else
         begin
            emwr_progfull = (c.op == op_stall);
            run_write(c, d, e);
         end
         repeat (2) @(negedge s_axi_aclk);
      end
      repeat (4) @(negedge s_axi_aclk);
      if (exp_wr_addr.size() != 0)
      begin
         errors = errors + 1;
         $display("%0d emesh write packets never appeared", exp_wr_addr.size());
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: common/esaxi_pkg.sv
`default_nettype none

package esaxi_pkg;

   // ####################
   // emesh address layout
   // ####################
   localparam int link_id_w = 12;    // chip link id
   localparam int group_w   = 4;     // register group inside the link
   localparam int offset_w  = 16;    // register offset inside the group

   localparam int addr_lsb  = 2;     // byte offset bits of a 32-bit word

   // one address word, seen flat by the bus side or split by the decoder
   typedef union packed {
      logic [31:0] word;
      struct packed {
         logic [link_id_w-1:0] link_id;
         logic [group_w-1:0]   group;
         logic [offset_w-1:0]  offset;
      } field;
   } emesh_addr_u;

   // ####################
   // axi codes
   // ####################
   localparam logic [1:0] burst_incr = 2'b01;
   localparam logic [1:0] size_byte  = 2'b00;   // 8-bit transfer
   localparam logic [1:0] size_half  = 2'b01;   // 16-bit transfer
   localparam logic [1:0] resp_okay  = 2'b00;

   // register groups behind the local link id
   localparam logic [group_w-1:0] group_mmr   = 4'hf;   // link config
   localparam logic [group_w-1:0] group_rxmmu = 4'he;
   localparam logic [group_w-1:0] group_txmmu = 4'hd;
   localparam logic [group_w-1:0] group_embox = 4'hc;   // mailbox

endpackage

`default_nettype wire

// File: design/esaxi.sv
`timescale 1ns/1ps
`default_nettype none

module esaxi
#(
   parameter int          axi_addr_width = 30,
   parameter logic [11:0] elink_id       = 12'h810,   // local link id
   parameter logic [11:0] read_tag_addr  = 12'h810    // read source tag
)
(
   input  wire                      s_axi_aclk,
   input  wire                      s_axi_aresetn,
   // axi write address and data
   input  wire [axi_addr_width-1:0] s_axi_awaddr,
   input  wire [1:0]                s_axi_awburst,
   input  wire [2:0]                s_axi_awsize,
   input  wire                      s_axi_awvalid,
   output wire                      s_axi_awready,
   input  wire [31:0]               s_axi_wdata,
   input  wire [3:0]                s_axi_wstrb,
   input  wire                      s_axi_wlast,
   input  wire                      s_axi_wvalid,
   output wire                      s_axi_wready,
   input  wire                      s_axi_bready,
   output wire                      s_axi_bvalid,
   output wire [1:0]                s_axi_bresp,
   // axi read address and data
   input  wire [axi_addr_width-1:0] s_axi_araddr,
   input  wire [1:0]                s_axi_arburst,
   input  wire [7:0]                s_axi_arlen,
   input  wire [2:0]                s_axi_arsize,
   input  wire                      s_axi_arvalid,
   output wire                      s_axi_arready,
   input  wire                      s_axi_rready,
   output wire                      s_axi_rvalid,
   output wire [31:0]               s_axi_rdata,
   output wire [1:0]                s_axi_rresp,
   output wire                      s_axi_rlast,
   // emesh write packets
   input  wire                      emwr_progfull,
   output wire                      emwr_access,
   output wire [1:0]                emwr_datamode,
   output wire [3:0]                emwr_ctrlmode,
   output wire [31:0]               emwr_dstaddr,
   output wire [31:0]               emwr_data,
   // emesh read requests
   output wire                      emrq_access,
   output wire [1:0]                emrq_datamode,
   output wire [3:0]                emrq_ctrlmode,
   output wire [31:0]               emrq_dstaddr,
   output wire [31:0]               emrq_srcaddr,
   // emesh read responses
   input  wire                      emrr_access,
   input  wire [31:0]               emrr_data,
   output wire                      emrr_rd_en,
   // register bus
   output wire                      mi_we,
   output wire [19:0]               mi_addr,
   output wire [31:0]               mi_din,
   output wire                      mi_ecfg_sel,
   output wire                      mi_rx_emmu_sel,
   output wire                      mi_tx_emmu_sel,
   output wire                      mi_embox_sel,
   input  wire [31:0]               mi_ecfg_dout,
   input  wire [31:0]               mi_rx_emmu_dout,
   input  wire [31:0]               mi_tx_emmu_dout,
   input  wire [31:0]               mi_embox_dout,
   // link config
   input  wire [3:0]                ecfg_tx_ctrlmode,
   input  wire [11:0]               ecfg_coreid
);

   wire        local_rd_valid;   // register readback strobe
   wire [31:0] local_rd_data;

   // ####################
   // write and read paths
   // ####################
   esaxi_write #(
      .axi_addr_width (axi_addr_width)
   ) u_write (
      .emwr_dstaddr   (emwr_dstaddr),
      .*
   );

   esaxi_read #(
      .axi_addr_width (axi_addr_width),
      .read_tag_addr  (read_tag_addr)
   ) u_read (
      .emrq_dstaddr   (emrq_dstaddr),
      .*
   );

   // local register decode on both packet streams
   esaxi_regif #(
      .elink_id       (elink_id)
   ) u_regif (
      .emwr_dstaddr   (emwr_dstaddr),
      .emrq_dstaddr   (emrq_dstaddr),
      .*
   );

endmodule

`default_nettype wire

// File: design/esaxi_regif.sv
`timescale 1ns/1ps
`default_nettype none

module esaxi_regif
   import esaxi_pkg::*;
#(
   parameter logic [link_id_w-1:0] elink_id = 12'h810
)
(
   input  wire                         s_axi_aclk,
   input  wire                         s_axi_aresetn,
   // packet streams from the write and read paths
   input  wire                         emwr_access,
   input  wire emesh_addr_u            emwr_dstaddr,
   input  wire [31:0]                  emwr_data,
   input  wire                         emrq_access,
   input  wire emesh_addr_u            emrq_dstaddr,
   // register bus
   output logic                        mi_we,
   output logic [group_w+offset_w-1:0] mi_addr,
   output logic [31:0]                 mi_din,
   output logic                        mi_ecfg_sel,
   output logic                        mi_rx_emmu_sel,
   output logic                        mi_tx_emmu_sel,
   output logic                        mi_embox_sel,
   input  wire [31:0]                  mi_ecfg_dout,
   input  wire [31:0]                  mi_rx_emmu_dout,
   input  wire [31:0]                  mi_tx_emmu_dout,
   input  wire [31:0]                  mi_embox_dout,
   // readback to the read path
   output logic                        local_rd_valid,
   output logic [31:0]                 local_rd_data
);

   logic               mi_wr;       // local write this cycle
   logic               mi_rd;       // local read this cycle
   logic               mi_en;
   logic [group_w-1:0] mi_group;
   logic               ecfg_q;      // selects seen by last cycle's read
   logic               rx_emmu_q;
   logic               tx_emmu_q;
   logic               embox_q;

   // ####################
   // decode
   // ####################
   assign mi_wr    = emwr_access & (emwr_dstaddr.field.link_id == elink_id);
   assign mi_rd    = emrq_access & (emrq_dstaddr.field.link_id == elink_id);
   assign mi_en    = mi_wr | mi_rd;
   assign mi_we    = mi_wr;
   assign mi_din   = emwr_data;   // 32-bit writes only
   assign mi_addr  = mi_wr ? {emwr_dstaddr.field.group, emwr_dstaddr.field.offset}
                           : {emrq_dstaddr.field.group, emrq_dstaddr.field.offset};
   assign mi_group = mi_addr[group_w+offset_w-1:offset_w];

   assign mi_ecfg_sel    = mi_en & (mi_group == group_mmr);
   assign mi_rx_emmu_sel = mi_en & (mi_group == group_rxmmu);
   assign mi_tx_emmu_sel = mi_en & (mi_group == group_txmmu);
   assign mi_embox_sel   = mi_en & (mi_group == group_embox);

   // ####################
   // readback
   // ####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ecfg_q         <= 1'b0;
         rx_emmu_q      <= 1'b0;
         tx_emmu_q      <= 1'b0;
         embox_q        <= 1'b0;
         local_rd_valid <= 1'b0;
      end
      else
      begin
         ecfg_q         <= mi_ecfg_sel;
         rx_emmu_q      <= mi_rx_emmu_sel;
         tx_emmu_q      <= mi_tx_emmu_sel;
         embox_q        <= mi_embox_sel;
         local_rd_valid <= mi_rd;   // register data valid one cycle later
      end
   end

   always_comb
   begin
      if (ecfg_q)
         local_rd_data = mi_ecfg_dout;
      else if (rx_emmu_q)
         local_rd_data = mi_rx_emmu_dout;
      else if (tx_emmu_q)
         local_rd_data = mi_tx_emmu_dout;
      else
         local_rd_data = mi_embox_dout;   // embox or unknown group
   end

endmodule

`default_nettype wire

// File: esaxi.f
+incdir+bench
common/esaxi_pkg.sv
axi_write/esaxi_write.sv
axi_read/esaxi_read.sv
design/esaxi_regif.sv
design/esaxi.sv
bench/esaxi_tb.sv
